// File: run_sim.sh
#!/bin/sh
# Build and run the register stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module rv_regstage_tb \
  -Mdir obj_dir \
  -f rv_regstage_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vrv_regstage_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: rv_decode.sv
`timescale 1ns/1ps
// Instruction decoder for the register stage
// Source address slicing towards the register file
// OP and OP-IMM decode into ALU operations
// I-type immediate sign extension
// Decoded-field pipeline register, held under stall
`include "rv_settings.svh"

module rv_decode
  import rv_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                stall_i,
  input  logic [31:0]         instr_i,
  input  logic                instr_valid_i,
  output rsd_t                rf_src1_o,
  output rsd_t                rf_src2_o,
  output logic                id_valid_o,
  output alu_op_e             id_alu_op_o,
  output logic                id_use_imm_o,
  output logic [`RV_XLEN-1:0] id_imm_o,
  output rsd_t                id_rd_o,
  output rsd_t                id_rs1_o,
  output rsd_t                id_rs2_o
);

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_d;
  alu_op_e             alu_op_d;
  logic                use_imm_d;
  logic                legal_d;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register file latches these itself, so they go out straight from the word
  assign rf_src1_o = instr_i[19:15];
  assign rf_src2_o = instr_i[24:20];

  // I-type immediate, sign bit is instr[31]
  assign imm_d = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};

  ////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////

  always_comb
  begin
    alu_op_d  = ALU_ADD;
    use_imm_d = 1'b0;
    legal_d   = 1'b0;
    case (opcode)
      OPC_OP:
      begin
        // Base register-register group
        if (funct7 == 7'b0000000)
        begin
          legal_d = 1'b1;
          case (funct3)
            3'b000:  alu_op_d = ALU_ADD;
            3'b010:  alu_op_d = ALU_SLT;
            3'b100:  alu_op_d = ALU_XOR;
            3'b110:  alu_op_d = ALU_OR;
            3'b111:  alu_op_d = ALU_AND;
            default: legal_d  = 1'b0;
          endcase
        end
        // Alternate encoding, only SUB is kept
        else if (funct7 == 7'b0100000 && funct3 == 3'b000)
        begin
          legal_d  = 1'b1;
          alu_op_d = ALU_SUB;
        end
      end
      OPC_OP_IMM:
      begin
        use_imm_d = 1'b1;
        // ADDI and XORI only
        case (funct3)
          3'b000:
          begin
            legal_d  = 1'b1;
            alu_op_d = ALU_ADD;
          end
          3'b100:
          begin
            legal_d  = 1'b1;
            alu_op_d = ALU_XOR;
          end
          default: legal_d = 1'b0;
        endcase
      end
      // Loads, stores, branches and the rest become bubbles
      default: legal_d = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////

  // Valid is control state and gets the reset
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      id_valid_o <= 1'b0;
    else if (!stall_i)
      id_valid_o <= instr_valid_i & legal_d;
  end

  // Payload fields
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      id_alu_op_o  <= alu_op_d;
      id_use_imm_o <= use_imm_d;
      id_imm_o     <= imm_d;
      id_rd_o      <= instr_i[11:7];
      // Same addresses the register file latched, used for the forwarding compare
      id_rs1_o     <= instr_i[19:15];
      id_rs2_o     <= instr_i[24:20];
    end
  end

  // A valid decoded slot always carries one of the six ALU encodings
  a_legal_alu_op : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    id_valid_o |-> (id_alu_op_o inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT})
  );

endmodule

// File: rv_execute.sv
`timescale 1ns/1ps
// Execute stage
// One-level result forwarding into both operands
// Immediate select and single-cycle ALU
// Result register driving writeback
`include "rv_settings.svh"

module rv_execute
  import rv_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                stall_i,

  // Decoded instruction
  input  logic                id_valid_i,
  input  alu_op_e             id_alu_op_i,
  input  logic                id_use_imm_i,
  input  logic [`RV_XLEN-1:0] id_imm_i,
  input  rsd_t                id_rd_i,
  input  rsd_t                id_rs1_i,
  input  rsd_t                id_rs2_i,

  // Operands from the register file
  input  logic [`RV_XLEN-1:0] op1_i,
  input  logic [`RV_XLEN-1:0] op2_i,

  // Writeback
  output logic                wb_we_o,
  output rsd_t                wb_rd_o,
  output logic [`RV_XLEN-1:0] wb_data_o
);

  ////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////

  logic                valid_q;
  logic                fwd1;
  logic                fwd2;
  logic [`RV_XLEN-1:0] opa;
  logic [`RV_XLEN-1:0] opb_reg;
  logic [`RV_XLEN-1:0] opb;
  logic [`RV_XLEN-1:0] alu_res;

  // Previous result is not in the array yet when the very next
  // instruction reads it, so take it from the result register.
  // wb_we_o already excludes x0 and invalid slots
  assign fwd1 = wb_we_o && (wb_rd_o == id_rs1_i);
  assign fwd2 = wb_we_o && (wb_rd_o == id_rs2_i);

  assign opa     = fwd1 ? wb_data_o : op1_i;
  assign opb_reg = fwd2 ? wb_data_o : op2_i;

  // OP-IMM takes the sign-extended immediate
  assign opb = id_use_imm_i ? id_imm_i : opb_reg;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb
  begin
    case (id_alu_op_i)
      ALU_ADD: alu_res = opa + opb;
      ALU_SUB: alu_res = opa - opb;
      ALU_AND: alu_res = opa & opb;
      ALU_OR:  alu_res = opa | opb;
      ALU_XOR: alu_res = opa ^ opb;
      // Signed compare
      ALU_SLT: alu_res = {{(`RV_XLEN-1){1'b0}}, ($signed(opa) < $signed(opb))};
      default: alu_res = '0;
    endcase
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else if (!stall_i)
      valid_q <= id_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      wb_rd_o   <= id_rd_i;
      wb_data_o <= alu_res;
    end
  end

  // x0 destinations never write back
  assign wb_we_o = valid_q && (wb_rd_o != '0);

  // An instruction aimed at x0 leaves no write strobe behind it
  a_wb_not_x0 : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (!stall_i && id_valid_i && (id_rd_i == '0)) |=> !wb_we_o
  );

  // A write strobe always carries defined data
  a_wb_data_known : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_we_o |-> !$isunknown(wb_data_o)
  );

endmodule

// File: rv_pkg.sv
// Shared types for the register stage
// Register address type
// Major opcode encodings for the supported groups
// ALU operation encodings
package rv_pkg;

  ////////////////////////////////////////
  // Register addressing
  ////////////////////////////////////////

  // Architectural register index, x0 up to x31
  typedef logic [4:0] rsd_t;

  ////////////////////////////////////////
  // Opcodes and ALU operations
  ////////////////////////////////////////

  // Major opcode, bits [6:0] of the instruction word
  // Anything not listed here decodes as a bubble
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011
  } opcode_e;

  // ALU operation selected by decode
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

endpackage

// File: rv_regfile.sv
`timescale 1ns/1ps
// Integer register file
// Registered source addresses with x0 detection
// Asynchronous operand read from the array
// Synchronous write, debug port ahead of the pipeline
// Combinational debug readback
`include "rv_settings.svh"

module rv_regfile
  import rv_pkg::*;
(
  input  logic                clk_i,
  input  logic                stall_i,

  // Operand read
  input  rsd_t                rf_src1_i,
  input  rsd_t                rf_src2_i,
  output logic [`RV_XLEN-1:0] rf_src1_q_o,
  output logic [`RV_XLEN-1:0] rf_src2_q_o,

  // Writeback from execute
  input  logic                wb_we_i,
  input  rsd_t                wb_rd_i,
  input  logic [`RV_XLEN-1:0] wb_data_i,

  // Debug access
  input  logic                du_we_i,
  input  logic [11:0]         du_addr_i,
  input  logic [`RV_XLEN-1:0] du_d_i,
  output logic [`RV_XLEN-1:0] du_q_o
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Entry 0 exists but is never seen through any read port
  logic [`RV_XLEN-1:0] rf [`RV_NREGS];

  rsd_t src1_q;
  rsd_t src2_q;
  logic src1_is_x0;
  logic src2_is_x0;

  // Debug register select, upper address bits are ignored
  rsd_t du_sel;

  assign du_sel = du_addr_i[4:0];

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // Address latch, frozen together with the rest of the pipeline
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      src1_q     <= rf_src1_i;
      src2_q     <= rf_src2_i;
      // Precompute the x0 test so the read path only has a mux
      src1_is_x0 <= (rf_src1_i == '0);
      src2_is_x0 <= (rf_src2_i == '0);
    end
  end

  // Array read is asynchronous, so a write at the edge is visible right after
  assign rf_src1_q_o = src1_is_x0 ? '0 : rf[src1_q];
  assign rf_src2_q_o = src2_is_x0 ? '0 : rf[src2_q];

  // Debug readback
  assign du_q_o = (du_sel == '0) ? '0 : rf[du_sel];

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  // Not gated by stall, a held writeback just rewrites the same value
  always_ff @(posedge clk_i)
  begin
    if (du_we_i)
      rf[du_sel] <= du_d_i;
    else if (wb_we_i)
      rf[wb_rd_i] <= wb_data_i;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Debug unit halts the core before touching registers,
  // so a debug write never competes with a live writeback
  a_du_write_stalled : assert property (
    @(posedge clk_i)
    !(du_we_i && wb_we_i && !stall_i)
  );

endmodule

// File: rv_regstage_tb.sv
`timescale 1ns/1ps
// Testbench for the register stage
// Stimulus table with a sequential reference register model
// Debug preload and readback, result monitor with stall checks
// Watchdog sized from the test length
`include "rv_settings.svh"

module rv_regstage_tb
  import rv_pkg::*;
();

  logic                clk_i;
  logic                rst_n_i;
  logic [31:0]         instr_i;
  logic                instr_valid_i;
  logic                stall_i;
  logic                du_we_i;
  logic [11:0]         du_addr_i;
  logic [`RV_XLEN-1:0] du_d_i;
  logic [`RV_XLEN-1:0] du_q_o;
  logic [`RV_XLEN-1:0] result_o;
  rsd_t                result_rd_o;
  logic                result_valid_o;

  // Stimulus table, one entry per cycle
  string               row_name [$];
  logic [31:0]         row_instr [$];
  logic                row_vld [$];
  logic                row_stall [$];
  int                  row_slot [$];
  // Expected results in issue order, slot is the unstalled cycle they show up in
  string               exp_name [$];
  rsd_t                exp_rd [$];
  logic [`RV_XLEN-1:0] exp_val [$];
  int                  exp_slot [$];
  logic [`RV_XLEN-1:0] ref_rf [`RV_NREGS];

  int                  slot_cnt = 0;
  int                  exp_total = 0;
  int                  n_seen = 0;
  int                  row_idx = 0;
  logic                running = 1'b0;
  logic                table_ready = 1'b0;
  logic                stall_prev = 1'b0;
  logic                valid_prev = 1'b0;
  logic [`RV_XLEN-1:0] res_prev = '0;

  rv_regstage_top rv_regstage_top_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_i        (instr_i),
    .instr_valid_i  (instr_valid_i),
    .stall_i        (stall_i),
    .du_we_i        (du_we_i),
    .du_addr_i      (du_addr_i),
    .du_d_i         (du_d_i),
    .du_q_o         (du_q_o),
    .result_o       (result_o),
    .result_rd_o    (result_rd_o),
    .result_valid_o (result_valid_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic stop_with_fail();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(string name, logic [`RV_XLEN-1:0] exp,
                                 logic [`RV_XLEN-1:0] act);
    $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
    stop_with_fail();
  endtask

  task automatic report_error(string msg);
    $display("ERROR: %s", msg);
    stop_with_fail();
  endtask

  ////////////////////////////////////////
  // Reference model and table building
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic add_row(string name, logic [31:0] word, logic vld, logic stall);
    row_name.push_back(name);
    row_instr.push_back(word);
    row_vld.push_back(vld);
    row_stall.push_back(stall);
    row_slot.push_back(slot_cnt);
    if (!stall)
      slot_cnt++;
  endtask

  task automatic add_gap(int n);
    for (int k = 0; k < n; k++)
      add_row("gap", 32'h0, 1'b0, 1'b0);
  endtask

  // Writes to x0 are dropped and give no result
  task automatic expect_result(string name, rsd_t rd, logic [`RV_XLEN-1:0] val);
    if (rd != '0)
    begin
      ref_rf[rd] = val;
      exp_name.push_back(name);
      exp_rd.push_back(rd);
      exp_val.push_back(val);
      // Issued in slot_cnt-1, visible two unstalled cycles later
      exp_slot.push_back(slot_cnt + 1);
    end
  endtask

  task automatic issue_r(string name, logic [6:0] f7, logic [2:0] f3,
                         rsd_t rd, rsd_t rs1, rsd_t rs2);
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] r;
    a = ref_rf[rs1];
    b = ref_rf[rs2];
    case (f3)
      3'b000:  r = f7[5] ? a - b : a + b;
      3'b010:  r = ($signed(a) < $signed(b)) ? `RV_XLEN'(1) : '0;
      3'b100:  r = a ^ b;
      3'b110:  r = a | b;
      3'b111:  r = a & b;
      default: r = '0;
    endcase
    add_row(name, {f7, rs2, rs1, f3, rd, 7'b0110011}, 1'b1, 1'b0);
    expect_result(name, rd, r);
  endtask

  task automatic issue_i(string name, logic [2:0] f3, rsd_t rd, rsd_t rs1,
                         logic [11:0] imm);
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    a = ref_rf[rs1];
    b = {{(`RV_XLEN-12){imm[11]}}, imm};
    add_row(name, {imm, rs1, f3, rd, 7'b0010011}, 1'b1, 1'b0);
    expect_result(name, rd, (f3 == 3'b100) ? a ^ b : a + b);
  endtask

  task automatic build_table();
    // One ALU operation each, a bubble before any dependent
    issue_r("add", 7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    add_gap(1);
    issue_r("sub", 7'h20, 3'b000, 5'd4, 5'd3, 5'd5);
    add_gap(1);
    issue_r("and", 7'h00, 3'b111, 5'd6, 5'd4, 5'd7);
    add_gap(1);
    issue_r("or", 7'h00, 3'b110, 5'd8, 5'd6, 5'd9);
    add_gap(1);
    issue_r("xor", 7'h00, 3'b100, 5'd10, 5'd8, 5'd11);
    add_gap(1);
    issue_r("slt", 7'h00, 3'b010, 5'd12, 5'd10, 5'd13);
    add_gap(1);
    issue_i("addi", 3'b000, 5'd14, 5'd12, 12'h7ff);
    add_gap(1);
    issue_i("xori", 3'b100, 5'd15, 5'd14, 12'h800);
    add_gap(1);
    issue_r("slt_neg", 7'h00, 3'b010, 5'd16, 5'd15, 5'd14);
    add_gap(1);
    // Back to back, forwarded on rs1 then rs2, then two apart
    issue_r("fwd_add", 7'h00, 3'b000, 5'd17, 5'd1, 5'd2);
    issue_r("fwd_rs1_sub", 7'h20, 3'b000, 5'd18, 5'd17, 5'd3);
    issue_r("fwd_rs2_xor", 7'h00, 3'b100, 5'd19, 5'd4, 5'd18);
    issue_r("dist2_and", 7'h00, 3'b111, 5'd20, 5'd18, 5'd5);
    issue_i("fwd_addi_self", 3'b000, 5'd20, 5'd20, 12'hfff);
    // x0 as destination must not forward into the next one
    issue_r("rd0_add", 7'h00, 3'b000, 5'd0, 5'd1, 5'd2);
    issue_r("x0_src_add", 7'h00, 3'b000, 5'd21, 5'd0, 5'd1);
    issue_i("x0_src_addi", 3'b000, 5'd22, 5'd0, 12'h123);
    // Stall between producer and consumer, a live ADD sits on the bus meanwhile
    issue_i("pre_stall", 3'b000, 5'd24, 5'd21, 12'h005);
    for (int k = 0; k < 4; k++)
      add_row("stall", {7'h00, 5'd2, 5'd1, 3'b000, 5'd7, 7'b0110011}, 1'b1, 1'b1);
    issue_r("post_stall", 7'h00, 3'b000, 5'd25, 5'd24, 5'd24);
    issue_r("post_stall_xor", 7'h00, 3'b100, 5'd26, 5'd25, 5'd24);
    // LW and SLL become bubbles
    add_row("load", {12'd4, 5'd1, 3'b010, 5'd9, 7'b0000011}, 1'b1, 1'b0);
    add_row("sll", {7'h00, 5'd2, 5'd1, 3'b001, 5'd9, 7'b0110011}, 1'b1, 1'b0);
    issue_r("after_load", 7'h00, 3'b000, 5'd27, 5'd9, 5'd1);
    // Drain the pipeline
    add_gap(3);
    exp_total = exp_slot.size();
  endtask

  ////////////////////////////////////////
  // Debug port
  ////////////////////////////////////////

  // Upper address bits set on purpose, only the low 5 select
  task automatic check_registers(string tag);
    for (int r = 0; r < `RV_NREGS; r++)
    begin
      @(posedge clk_i);
      du_addr_i <= {7'h2c, 5'(r)};
      @(negedge clk_i);
      // ref_rf[0] stays zero whatever was written to x0
      assert (du_q_o == ref_rf[r])
        else report_mismatch($sformatf("%s_x%0d", tag, r), ref_rf[r], du_q_o);
    end
  endtask

  ////////////////////////////////////////
  // Result monitor
  ////////////////////////////////////////

  always @(negedge clk_i)
  begin
    // Every unstalled valid cycle counts, also outside the table window
    if (!stall_i && result_valid_o)
      n_seen++;
    if (running)
    begin
      // Outputs frozen across a stalled edge
      if (stall_prev)
      begin
        assert (result_valid_o == valid_prev)
          else report_mismatch("stall_hold_valid", `RV_XLEN'(valid_prev),
                               `RV_XLEN'(result_valid_o));
        assert (result_o == res_prev)
          else report_mismatch("stall_hold_result", res_prev, result_o);
      end
      // Check a result once, in its last cycle before an unstalled edge
      if (!stall_i)
      begin
        if (result_valid_o)
        begin
          assert (exp_slot.size() != 0)
            else report_error("result_valid_o high with no result pending");
          assert (exp_slot[0] == row_slot[row_idx])
            else report_mismatch($sformatf("%s_slot", exp_name[0]),
                                 `RV_XLEN'(exp_slot[0]), `RV_XLEN'(row_slot[row_idx]));
          assert (result_rd_o == exp_rd[0])
            else report_mismatch($sformatf("%s_rd", exp_name[0]),
                                 `RV_XLEN'(exp_rd[0]), `RV_XLEN'(result_rd_o));
          assert (result_o == exp_val[0])
            else report_mismatch(exp_name[0], exp_val[0], result_o);
          void'(exp_name.pop_front());
          void'(exp_rd.pop_front());
          void'(exp_val.pop_front());
          void'(exp_slot.pop_front());
        end
        else if (exp_slot.size() != 0)
        begin
          assert (exp_slot[0] != row_slot[row_idx])
            else report_error($sformatf("no valid result for %s", exp_name[0]));
        end
      end
      stall_prev = stall_i;
      valid_prev = result_valid_o;
      res_prev   = result_o;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    logic [31:0] rnd;
    rst_n_i       = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    stall_i       = 1'b0;
    du_we_i       = 1'b0;
    du_addr_i     = '0;
    du_d_i        = '0;
    ref_rf[0]     = '0;
    rnd           = 32'd17012;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Preload every register with the core stalled, x0 included
    @(posedge clk_i);
    stall_i <= 1'b1;
    for (int r = 0; r < `RV_NREGS; r++)
    begin
      rnd = xorshift32(rnd);
      @(posedge clk_i);
      du_we_i   <= 1'b1;
      du_addr_i <= {7'h2c, 5'(r)};
      du_d_i    <= `RV_XLEN'(rnd);
      if (r != 0)
        ref_rf[r] = `RV_XLEN'(rnd);
    end
    @(posedge clk_i);
    du_we_i <= 1'b0;
    stall_i <= 1'b0;
    check_registers("preload");

    build_table();
    table_ready = 1'b1;
    for (int i = 0; i < row_name.size(); i++)
    begin
      @(posedge clk_i);
      instr_i       <= row_instr[i];
      instr_valid_i <= row_vld[i];
      stall_i       <= row_stall[i];
      row_idx       <= i;
      running       <= 1'b1;
    end
    @(posedge clk_i);
    running       <= 1'b0;
    instr_valid_i <= 1'b0;
    stall_i       <= 1'b0;

    assert (exp_slot.size() == 0)
      else report_error("results still pending after the table");
    assert (n_seen == exp_total)
      else report_mismatch("valid_count", `RV_XLEN'(exp_total), `RV_XLEN'(n_seen));
    check_registers("final");

    $display("STATUS: PASS");
    $finish;
  end

  // Table rows plus one debug readback, four cycles each, and some slack
  initial
  begin
    wait (table_ready);
    repeat ((row_name.size() + `RV_NREGS) * 4 + 50) @(posedge clk_i);
    report_error("watchdog timeout, the test sequence did not finish");
  end

endmodule

// File: rv_regstage_top.f
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_regstage_top.sv
rv_regstage_tb.sv

// File: rv_regstage_top.sv
`timescale 1ns/1ps
// Register stage top level
// Decode, register file and execute wired into one pipeline
// Writeback result and debug readback exposed as outputs
`include "rv_settings.svh"

module rv_regstage_top
  import rv_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Instruction input
  input  logic [31:0]         instr_i,
  input  logic                instr_valid_i,
  input  logic                stall_i,

  // Debug port
  input  logic                du_we_i,
  input  logic [11:0]         du_addr_i,
  input  logic [`RV_XLEN-1:0] du_d_i,
  output logic [`RV_XLEN-1:0] du_q_o,

  // Writeback result
  output logic [`RV_XLEN-1:0] result_o,
  output rsd_t                result_rd_o,
  output logic                result_valid_o
);

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  // Decode to register file
  rsd_t                rf_src1;
  rsd_t                rf_src2;

  // Decode to execute
  logic                id_valid;
  alu_op_e             id_alu_op;
  logic                id_use_imm;
  logic [`RV_XLEN-1:0] id_imm;
  rsd_t                id_rd;
  rsd_t                id_rs1;
  rsd_t                id_rs2;

  // Register file to execute
  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;

  // Execute back to register file
  logic                wb_we;
  rsd_t                wb_rd;
  logic [`RV_XLEN-1:0] wb_data;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  rv_decode rv_decode_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .rf_src1_o     (rf_src1),
    .rf_src2_o     (rf_src2),
    .id_valid_o    (id_valid),
    .id_alu_op_o   (id_alu_op),
    .id_use_imm_o  (id_use_imm),
    .id_imm_o      (id_imm),
    .id_rd_o       (id_rd),
    .id_rs1_o      (id_rs1),
    .id_rs2_o      (id_rs2)
  );

  rv_regfile rv_regfile_inst (
    .clk_i       (clk_i),
    .stall_i     (stall_i),
    .rf_src1_i   (rf_src1),
    .rf_src2_i   (rf_src2),
    .rf_src1_q_o (op1),
    .rf_src2_q_o (op2),
    .wb_we_i     (wb_we),
    .wb_rd_i     (wb_rd),
    .wb_data_i   (wb_data),
    .du_we_i     (du_we_i),
    .du_addr_i   (du_addr_i),
    .du_d_i      (du_d_i),
    .du_q_o      (du_q_o)
  );

  rv_execute rv_execute_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .id_valid_i   (id_valid),
    .id_alu_op_i  (id_alu_op),
    .id_use_imm_i (id_use_imm),
    .id_imm_i     (id_imm),
    .id_rd_i      (id_rd),
    .id_rs1_i     (id_rs1),
    .id_rs2_i     (id_rs2),
    .op1_i        (op1),
    .op2_i        (op2),
    .wb_we_o      (wb_we),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  // Writeback doubles as the result port
  assign result_o       = wb_data;
  assign result_rd_o    = wb_rd;
  assign result_valid_o = wb_we;

endmodule

// File: rv_settings.svh
// Global sizing for the register stage
// Data path width and architectural register count
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

// Integer register width, 32 for RV32 or 64 for RV64
`define RV_XLEN 32

////////////////////////////////////////
// Register file
////////////////////////////////////////

// Number of integer registers, x0 included
`define RV_NREGS 32

`endif
